//--- hw/globalHistoryTable.sv
// indexes four slot banks by history and group address, steers repair writes, packs the prediction
`default_nettype none

module globalHistoryTable #(
    parameter int HIST_BITS   = 4,
    parameter int PC_IDX_BITS = 4
) (
    input  wire logic            clk,
    input  wire logic            reset_ghr,
    // lookup request
    input  wire logic            lookupValid_i,
    input  ijtcPkg::addr_t       fetchAddr_i,
    input  ijtcPkg::hist_t       curHist_i,
    // back-end update
    input  ijtcPkg::updateReq_t  updReq_i,
    // prediction, one cycle after the lookup
    output logic                 predValid_o,
    output ijtcPkg::predBundle_t pred_o
);
    import ijtcPkg::*;

    // index is {history, group address bits}
    localparam int IDX_BITS = HIST_BITS + PC_IDX_BITS;

    // ------------------------------------------------------------
    // lookup index
    // ------------------------------------------------------------

    logic [IDX_BITS-1:0] rdIdx;
    logic [IDX_BITS-1:0] wrIdx;
    logic                repairAct;
    slotIdx_t            repairSlot;

    // same index for all four slots of the group
    assign rdIdx = {curHist_i[HIST_BITS-1:0], fetchAddr_i[GROUP_LSB +: PC_IDX_BITS]};

    // ------------------------------------------------------------
    // repair write steering
    // ------------------------------------------------------------

    assign repairAct  = (updReq_i.action == UPD_REPAIR);
    // mispredicted slot inside its group
    assign repairSlot = updReq_i.errAddr[3:2];

    // written under the history the branch was predicted with
    assign wrIdx = {updReq_i.checkpoint[HIST_BITS-1:0],
                    updReq_i.errAddr[GROUP_LSB +: PC_IDX_BITS]};

    // ------------------------------------------------------------
    // slot banks
    // ------------------------------------------------------------

    addr_t [SLOTS-1:0] slotAddr;
    addr_t [SLOTS-1:0] bankTarget;
    logic  [SLOTS-1:0] bankHit;
    logic  [SLOTS-1:0] bankWrEn;

    for (genvar s = 0; s < SLOTS; s++) begin : gSlot
        // group address with the slot number in bits 3:2
        assign slotAddr[s] = {fetchAddr_i[ADDR_W-1:GROUP_LSB],
                              slotIdx_t'(s),
                              fetchAddr_i[1:0]};

        // one bank per repair, picked by the error address
        assign bankWrEn[s] = repairAct && (repairSlot == slotIdx_t'(s));

        targetBank #(
            .IDX_BITS (IDX_BITS)
        ) uBank (
            .clk        (clk),
            .reset_ghr  (reset_ghr),
            .rdIdx_i    (rdIdx),
            .slotAddr_i (slotAddr[s]),
            .wrEn_i     (bankWrEn[s]),
            .wrIdx_i    (wrIdx),
            .wrData_i   (updReq_i.target),
            .target_o   (bankTarget[s]),
            .hit_o      (bankHit[s])
        );
    end

    // ------------------------------------------------------------
    // result alignment
    // ------------------------------------------------------------

    hist_t checkpointQ;
    logic  predValidQ;

    // strobe lines up with the bank read registers
    always_ff @(posedge clk) begin
        if (reset_ghr) begin
            predValidQ <= 1'b0;
        end else begin
            predValidQ <= lookupValid_i;
        end
    end

    // history that formed this read index
    always_ff @(posedge clk) begin
        if (lookupValid_i) begin
            checkpointQ <= curHist_i;
        end
    end

    assign predValid_o = predValidQ;

    // slot 0 ends up in the low target word
    assign pred_o = '{
        targets:    bankTarget,
        hit:        bankHit,
        checkpoint: checkpointQ
    };

endmodule

`default_nettype wire

//--- hw/historyRegister.sv
// global history register, shifted by direct updates and restored by repairs, feeds the table index
`default_nettype none

module historyRegister #(
    parameter int HIST_BITS = 4
) (
    input  wire logic           clk,
    input  wire logic           reset_ghr,
    input  ijtcPkg::updateReq_t updReq_i,
    output ijtcPkg::hist_t      hist_o
);
    import ijtcPkg::*;

    // keeps only the live history bits
    localparam hist_t HIST_MASK = hist_t'((1 << HIST_BITS) - 1);

    // ------------------------------------------------------------
    // next-state decode
    // ------------------------------------------------------------

    hist_t histQ;
    hist_t histD;
    hist_t shifted;
    logic  histLoad;

    // direction enters at bit 0, oldest bit drops off the top
    assign shifted = ((histQ << 1) | hist_t'(updReq_i.taken)) & HIST_MASK;

    // action is one enum value, so repair and direct never overlap
    always_comb begin
        histD    = histQ;
        histLoad = 1'b0;
        case (updReq_i.action)
            UPD_DIRECT: begin
                histD    = shifted;
                histLoad = 1'b1;
            end
            UPD_REPAIR: begin
                // back to the snapshot taken at prediction time
                histD    = updReq_i.checkpoint & HIST_MASK;
                histLoad = 1'b1;
            end
            default: begin
                histD    = histQ;
                histLoad = 1'b0;
            end
        endcase
    end

    // ------------------------------------------------------------
    // register
    // ------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset_ghr) begin
            histQ <= '0;
        end else if (histLoad) begin
            histQ <= histD;
        end
    end

    // upper bits stay zero by the mask
    assign hist_o = histQ;

endmodule

`default_nettype wire

//--- hw/ijtcPkg.sv
// shared widths, types and structs for the indirect-jump target predictor, imported by every RTL module
`default_nettype none

package ijtcPkg;

    // ------------------------------------------------------------
    // widths
    // ------------------------------------------------------------

    // instruction address width
    parameter int ADDR_W = 32;
    // slots per 16-byte fetch group
    parameter int SLOTS = 4;
    // widest history the types can hold
    parameter int MAX_HIST = 8;
    // lowest address bit of the group index
    parameter int GROUP_LSB = 4;
    // invalid entry predicts slot address plus this
    parameter int FALLBACK_OFS = 8;

    // ------------------------------------------------------------
    // plain vector types
    // ------------------------------------------------------------

    // virtual address
    typedef logic [ADDR_W-1:0] addr_t;
    // history snapshot, only low HIST_BITS bits in use
    typedef logic [MAX_HIST-1:0] hist_t;
    // slot number inside a fetch group, address bits 3:2
    typedef logic [1:0] slotIdx_t;

    // back-end update kind
    typedef enum logic [1:0] {
        UPD_NONE   = 2'd0,
        UPD_DIRECT = 2'd1,
        UPD_REPAIR = 2'd2
    } updAction_e;

    // ------------------------------------------------------------
    // bundles
    // ------------------------------------------------------------

    // one update from the back end, valid for a single cycle
    typedef struct packed {
        updAction_e action;
        hist_t      checkpoint;
        addr_t      errAddr;
        logic       taken;
        addr_t      target;
    } updateReq_t;

    // lookup result, slot 0 in the low target word
    typedef struct packed {
        addr_t [SLOTS-1:0] targets;
        logic  [SLOTS-1:0] hit;
        hist_t             checkpoint;
    } predBundle_t;

endpackage

`default_nettype wire

//--- hw/ijtcTop.sv
// top level of the indirect-jump target predictor, joins the history register and the target table
`default_nettype none

module ijtcTop #(
    parameter int HIST_BITS   = 4,
    parameter int PC_IDX_BITS = 4
) (
    input  wire logic            clk,
    input  wire logic            reset_ghr,
    // fetch-side lookup
    input  wire logic            lookupValid_i,
    input  ijtcPkg::addr_t       fetchAddr_i,
    // back-end update, direct or repair
    input  ijtcPkg::updateReq_t  updReq_i,
    // prediction result
    output logic                 predValid_o,
    output ijtcPkg::predBundle_t pred_o
);
    import ijtcPkg::*;

    // ------------------------------------------------------------
    // history
    // ------------------------------------------------------------

    // history before the current edge, used by the lookup
    hist_t curHist;

    historyRegister #(
        .HIST_BITS (HIST_BITS)
    ) uHist (
        .clk       (clk),
        .reset_ghr (reset_ghr),
        .updReq_i  (updReq_i),
        .hist_o    (curHist)
    );

    // ------------------------------------------------------------
    // target table
    // ------------------------------------------------------------

    // update fans out to both blocks
    globalHistoryTable #(
        .HIST_BITS   (HIST_BITS),
        .PC_IDX_BITS (PC_IDX_BITS)
    ) uTable (
        .clk           (clk),
        .reset_ghr     (reset_ghr),
        .lookupValid_i (lookupValid_i),
        .fetchAddr_i   (fetchAddr_i),
        .curHist_i     (curHist),
        .updReq_i      (updReq_i),
        .predValid_o   (predValid_o),
        .pred_o        (pred_o)
    );

endmodule

`default_nettype wire

//--- hw/targetBank.sv
// target memory of one fetch slot with per-entry valid bits that globalHistoryTable instantiates per slot
`default_nettype none

module targetBank #(
    parameter int IDX_BITS = 8
) (
    input  wire logic                clk,
    input  wire logic                reset_ghr,
    // lookup side
    input  wire logic [IDX_BITS-1:0] rdIdx_i,
    input  ijtcPkg::addr_t           slotAddr_i,
    // repair write side
    input  wire logic                wrEn_i,
    input  wire logic [IDX_BITS-1:0] wrIdx_i,
    input  ijtcPkg::addr_t           wrData_i,
    // result one cycle after the lookup
    output ijtcPkg::addr_t           target_o,
    output logic                     hit_o
);
    import ijtcPkg::*;

    localparam int DEPTH = 2 ** IDX_BITS;

    // ------------------------------------------------------------
    // storage
    // ------------------------------------------------------------

    addr_t            targetMem [DEPTH];
    logic [DEPTH-1:0] entryValid;

    // registered read side
    addr_t rdData;
    logic  rdValid;
    addr_t fallbackQ;

    // valid bits set by a repair write
    always_ff @(posedge clk) begin
        if (reset_ghr) begin
            entryValid <= '0;
        end else if (wrEn_i) begin
            entryValid[wrIdx_i] <= 1'b1;
        end
    end

    // target array written by repairs
    always_ff @(posedge clk) begin
        if (wrEn_i) begin
            targetMem[wrIdx_i] <= wrData_i;
        end
    end

    // ------------------------------------------------------------
    // synchronous read
    // ------------------------------------------------------------

    // a same-edge write lands after this read so old data comes back
    always_ff @(posedge clk) begin
        if (reset_ghr) begin
            rdValid <= 1'b0;
        end else begin
            rdValid <= entryValid[rdIdx_i];
        end
    end

    always_ff @(posedge clk) begin
        rdData    <= targetMem[rdIdx_i];
        // sequential fallthrough of the slot
        fallbackQ <= slotAddr_i + addr_t'(FALLBACK_OFS);
    end

    // stored target only when the entry was written
    assign target_o = rdValid ? rdData : fallbackQ;
    assign hit_o    = rdValid;

endmodule

`default_nettype wire

//--- tb.f
hw/ijtcPkg.sv
hw/targetBank.sv
hw/historyRegister.sv
hw/globalHistoryTable.sv
hw/ijtcTop.sv
verification/ijtcChecker.sv
verification/tb_ijtc.sv

//--- verification/ijtcChecker.sv
// testbench checker that compares every DUT prediction with the expectation queued for its lookup
`default_nettype none

module ijtcChecker (
    input  wire logic                 clk,
    input  wire logic                 reset_ghr,
    // DUT result
    input  wire logic                 predValid_i,
    input  wire ijtcPkg::predBundle_t pred_i,
    // expectation of the lookup driven in the same cycle
    input  wire logic                 expValid_i,
    input  wire ijtcPkg::predBundle_t expPred_i,
    // end of stimulus
    input  wire logic                 finish_i,
    output logic                      done_o,
    output int                        mismatchCount_o,
    output int                        protocolCount_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import ijtcPkg::*;

    // lookups sampled by the DUT whose results are due at the next edge
    predBundle_t expQ[$];
    predBundle_t expHead;
    int          mismatchErrs = 0;
    int          protocolErrs = 0;
    bit          finishSeen = 1'b0;

    assign mismatchCount_o = mismatchErrs;
    assign protocolCount_o = protocolErrs;

    // per-slot target and hit compare followed by the checkpoint
    task automatic compareResult(input predBundle_t expv, input predBundle_t seen);
        int s;
        for (s = 0; s < SLOTS; s++) begin
            if (seen.targets[s] !== expv.targets[s]) begin
                $display("mismatch at %0t: slot %0d target expected %h seen %h",
                         $time, s, expv.targets[s], seen.targets[s]);
                mismatchErrs++;
            end
            if (seen.hit[s] !== expv.hit[s]) begin
                $display("mismatch at %0t: slot %0d hit expected %b seen %b",
                         $time, s, expv.hit[s], seen.hit[s]);
                mismatchErrs++;
            end
        end
        if (seen.checkpoint !== expv.checkpoint) begin
            $display("mismatch at %0t: checkpoint expected %h seen %h",
                     $time, expv.checkpoint, seen.checkpoint);
            mismatchErrs++;
        end
    endtask

    // ------------------------------------------------------------
    // per-edge compare
    // ------------------------------------------------------------

    always @(posedge clk) begin
        if (reset_ghr) begin
            // nothing in flight after a flush
            expQ.delete();
            done_o <= 1'b0;
        end else begin
            // result of the lookup sampled one edge ago
            if (predValid_i === 1'b1) begin
                if (expQ.size() == 0) begin
                    $display("at %0t the DUT gave a result with no lookup pending", $time);
                    protocolErrs++;
                end else begin
                    expHead = expQ.pop_front();
                    compareResult(expHead, pred_i);
                end
            end else if (predValid_i !== 1'b0) begin
                $display("at %0t predValid_o is unknown", $time);
                protocolErrs++;
            end
            // anything left missed its one-cycle slot
            if (expQ.size() != 0) begin
                $display("at %0t a lookup got no result one cycle after it was sampled", $time);
                protocolErrs++;
                expQ.delete();
            end
            if (expValid_i === 1'b1) begin
                expQ.push_back(expPred_i);
            end
            if (finish_i === 1'b1 && !finishSeen) begin
                finishSeen = 1'b1;
                done_o <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- verification/ijtc_trace.txt
// columns: lookup fetch action(0 none 1 direct 2 repair) ckpt errAddr taken target
//          expHit expCkpt expT0 expT1 expT2 expT3 gapOk, a lone e ends the trace
// after reset, all slots fall back
0 00000000 0 00 00000000 0 00000000 0 00 00000000 00000000 00000000 00000000 1
1 00001000 0 00 00000000 0 00000000 0 00 00001008 0000100c 00001010 00001014 1
1 00002040 0 00 00000000 0 00000000 0 00 00002048 0000204c 00002050 00002054 1
1 800000f0 0 00 00000000 0 00000000 0 00 800000f8 800000fc 80000100 80000104 1
// direct updates shift the history
0 00000000 1 00 00000000 1 00000000 0 00 00000000 00000000 00000000 00000000 1
1 00001000 0 00 00000000 0 00000000 0 01 00001008 0000100c 00001010 00001014 1
0 00000000 1 00 00000000 1 00000000 0 00 00000000 00000000 00000000 00000000 1
0 00000000 1 00 00000000 0 00000000 0 00 00000000 00000000 00000000 00000000 1
1 00002040 0 00 00000000 0 00000000 0 06 00002048 0000204c 00002050 00002054 1
0 00000000 1 00 00000000 1 00000000 0 00 00000000 00000000 00000000 00000000 1
0 00000000 1 00 00000000 1 00000000 0 00 00000000 00000000 00000000 00000000 1
1 00001000 0 00 00000000 0 00000000 0 0b 00001008 0000100c 00001010 00001014 1
0 00000000 1 00 00000000 0 00000000 0 00 00000000 00000000 00000000 00000000 1
0 00000000 1 00 00000000 0 00000000 0 00 00000000 00000000 00000000 00000000 1
1 800000f0 0 00 00000000 0 00000000 0 0c 800000f8 800000fc 80000100 80000104 1
0 00000000 1 00 00000000 1 00000000 0 00 00000000 00000000 00000000 00000000 1
1 00001000 0 00 00000000 0 00000000 0 09 00001008 0000100c 00001010 00001014 1
// repairs write one bank each
0 00000000 2 05 00001008 0 deadbeec 0 00 00000000 00000000 00000000 00000000 1
1 00001000 0 00 00000000 0 00000000 4 05 00001008 0000100c deadbeec 00001014 1
1 00002040 0 00 00000000 0 00000000 0 05 00002048 0000204c 00002050 00002054 1
0 00000000 2 05 00002040 0 00400100 0 00 00000000 00000000 00000000 00000000 1
1 00002040 0 00 00000000 0 00000000 1 05 00400100 0000204c 00002050 00002054 1
1 00001000 0 00 00000000 0 00000000 4 05 00001008 0000100c deadbeec 00001014 1
0 00000000 2 05 0000100c 0 12345678 0 00 00000000 00000000 00000000 00000000 1
1 00001000 0 00 00000000 0 00000000 c 05 00001008 0000100c deadbeec 12345678 1
// history restore, other history misses
0 00000000 1 00 00000000 1 00000000 0 00 00000000 00000000 00000000 00000000 1
1 00001000 0 00 00000000 0 00000000 0 0b 00001008 0000100c 00001010 00001014 1
0 00000000 1 00 00000000 0 00000000 0 00 00000000 00000000 00000000 00000000 1
0 00000000 2 03 800000f4 0 00003000 0 00 00000000 00000000 00000000 00000000 1
1 800000f0 0 00 00000000 0 00000000 2 03 800000f8 00003000 80000100 80000104 1
1 00001000 0 00 00000000 0 00000000 0 03 00001008 0000100c 00001010 00001014 1
0 00000000 2 05 00001000 0 00000a00 0 00 00000000 00000000 00000000 00000000 1
1 00001000 0 00 00000000 0 00000000 d 05 00000a00 0000100c deadbeec 12345678 1
// checkpoint upper bits masked off
0 00000000 2 f7 00002048 0 00005550 0 00 00000000 00000000 00000000 00000000 1
1 00002040 0 00 00000000 0 00000000 4 07 00002048 0000204c 00005550 00002054 1
// same-edge lookup and update, back to back
1 00002040 1 00 00000000 1 00000000 4 07 00002048 0000204c 00005550 00002054 0
1 00002040 1 00 00000000 0 00000000 0 0f 00002048 0000204c 00002050 00002054 0
1 00001000 0 00 00000000 0 00000000 0 0e 00001008 0000100c 00001010 00001014 0
1 00001000 2 0e 00001004 0 00007770 0 0e 00001008 0000100c 00001010 00001014 0
1 00001000 0 00 00000000 0 00000000 2 0e 00001008 00007770 00001010 00001014 0
1 00001000 2 0e 00001004 0 00008880 2 0e 00001008 00007770 00001010 00001014 0
1 00001000 0 00 00000000 0 00000000 2 0e 00001008 00008880 00001010 00001014 0
1 00002040 0 00 00000000 0 00000000 0 0e 00002048 0000204c 00002050 00002054 0
1 800000f0 0 00 00000000 0 00000000 0 0e 800000f8 800000fc 80000100 80000104 0
1 800000f0 2 03 800000fc 0 00009990 0 0e 800000f8 800000fc 80000100 80000104 0
1 800000f0 0 00 00000000 0 00000000 a 03 800000f8 00003000 80000100 00009990 1
// wrap-up
0 00000000 0 00 00000000 0 00000000 0 00 00000000 00000000 00000000 00000000 1
1 00001000 0 00 00000000 0 00000000 0 03 00001008 0000100c 00001010 00001014 1
0 00000000 1 00 00000000 0 00000000 0 00 00000000 00000000 00000000 00000000 1
1 00002040 0 00 00000000 0 00000000 0 06 00002048 0000204c 00002050 00002054 1
0 00000000 2 05 00001000 0 00000a00 0 00 00000000 00000000 00000000 00000000 1
1 00001000 0 00 00000000 0 00000000 d 05 00000a00 0000100c deadbeec 12345678 1
1 00002040 0 00 00000000 0 00000000 1 05 00400100 0000204c 00002050 00002054 1
0 00000000 0 00 00000000 0 00000000 0 00 00000000 00000000 00000000 00000000 1
e

//--- verification/tb_ijtc.sv
// testbench top for the indirect-jump target predictor that replays the trace file against the DUT
`default_nettype none

module tb_ijtc;
    timeunit 1ns;
    timeprecision 1ps;
    import ijtcPkg::*;

    // ------------------------------------------------------------
    // run constants
    // ------------------------------------------------------------

    localparam int          HIST_BITS    = 4;
    localparam int          PC_IDX_BITS  = 4;
    localparam int          CLK_PERIOD   = 20;
    localparam int          RESET_CYCLES = 8;
    // idle cycles allowed after a row marked for gaps
    localparam int          MAX_GAP      = 2;
    // tokens per trace row
    localparam int          FIELDS       = 14;
    localparam int          MAX_ROWS     = 128;
    localparam logic [31:0] END_MARK     = 32'he;
    localparam logic [31:0] SEED         = 32'hab3e_7f19;

    // one trace row holding stimulus and expected result
    typedef struct packed {
        logic        lookup;
        addr_t       fetch;
        updateReq_t  upd;
        predBundle_t expPred;
        logic        gapOk;
    } traceRow_t;

    logic        clk;
    logic        reset_ghr;
    logic        lookupValid;
    addr_t       fetchAddr;
    updateReq_t  updReq;
    logic        predValid;
    predBundle_t pred;
    // handoff to the checker
    logic        expValid;
    predBundle_t expPred;
    logic        finishChecks;
    logic        checkDone;
    int          mismatchCount;
    int          protocolCount;

    logic [31:0] traceMem [FIELDS*MAX_ROWS];
    traceRow_t   rows[$];
    int          traceErrors;
    bit          traceLoaded = 1'b0;
    int unsigned gapLen;
    int unsigned watchdogCycles;
    int          totalErrors;

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    ijtcTop #(
        .HIST_BITS   (HIST_BITS),
        .PC_IDX_BITS (PC_IDX_BITS)
    ) DUT (
        .clk           (clk),
        .reset_ghr     (reset_ghr),
        .lookupValid_i (lookupValid),
        .fetchAddr_i   (fetchAddr),
        .updReq_i      (updReq),
        .predValid_o   (predValid),
        .pred_o        (pred)
    );

    ijtcChecker uChecker (
        .clk             (clk),
        .reset_ghr       (reset_ghr),
        .predValid_i     (predValid),
        .pred_i          (pred),
        .expValid_i      (expValid),
        .expPred_i       (expPred),
        .finish_i        (finishChecks),
        .done_o          (checkDone),
        .mismatchCount_o (mismatchCount),
        .protocolCount_o (protocolCount)
    );

    // ------------------------------------------------------------
    // trace loading
    // ------------------------------------------------------------

    // unpacks one row of the flat token memory
    function automatic traceRow_t decodeRow(input int row);
        traceRow_t r;
        int        b;
        int        s;
        b                    = row * FIELDS;
        r.lookup             = traceMem[b][0];
        r.fetch              = traceMem[b+1];
        r.upd.action         = updAction_e'(traceMem[b+2][1:0]);
        r.upd.checkpoint     = hist_t'(traceMem[b+3]);
        r.upd.errAddr        = traceMem[b+4];
        r.upd.taken          = traceMem[b+5][0];
        r.upd.target         = traceMem[b+6];
        r.expPred.hit        = traceMem[b+7][SLOTS-1:0];
        r.expPred.checkpoint = hist_t'(traceMem[b+8]);
        for (s = 0; s < SLOTS; s++) begin
            r.expPred.targets[s] = traceMem[b+9+s];
        end
        r.gapOk = traceMem[b+13][0];
        return r;
    endfunction

    task automatic loadTrace();
        int          r;
        logic [31:0] flag;
        $readmemh("verification/ijtc_trace.txt", traceMem);
        r = 0;
        while (r < MAX_ROWS && traceMem[r*FIELDS] !== END_MARK) begin
            flag = traceMem[r*FIELDS];
            if (flag !== 32'd0 && flag !== 32'd1) begin
                $display("trace row %0d has a bad lookup flag %h", r, flag);
                traceErrors++;
                break;
            end
            rows.push_back(decodeRow(r));
            r++;
        end
        if (r == MAX_ROWS) begin
            $display("trace file has no end marker");
            traceErrors++;
        end
        if (rows.size() == 0) begin
            $display("trace file holds no usable rows");
            traceErrors++;
        end
    endtask

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------

    task automatic driveRow(input traceRow_t r);
        lookupValid <= r.lookup;
        fetchAddr   <= r.fetch;
        updReq      <= r.upd;
        expValid    <= r.lookup;
        expPred     <= r.expPred;
    endtask

    // action zero is UPD_NONE
    task automatic driveIdle();
        lookupValid <= 1'b0;
        updReq      <= '0;
        expValid    <= 1'b0;
    endtask

    initial begin
        void'($urandom(SEED));
        reset_ghr    = 1'b1;
        lookupValid  = 1'b0;
        fetchAddr    = '0;
        updReq       = '0;
        expValid     = 1'b0;
        expPred      = '0;
        finishChecks = 1'b0;
        traceErrors  = 0;
        loadTrace();
        watchdogCycles = rows.size() * (1 + MAX_GAP) + 20;
        traceLoaded    = 1'b1;
        if (traceErrors != 0) begin
            $display("trace could not be loaded, no stimulus applied");
        end else begin
            repeat (RESET_CYCLES) @(posedge clk);
            reset_ghr <= 1'b0;
            foreach (rows[i]) begin
                @(posedge clk);
                driveRow(rows[i]);
                gapLen = rows[i].gapOk ? $urandom % (MAX_GAP + 1) : 0;
                repeat (gapLen) begin
                    @(posedge clk);
                    driveIdle();
                end
            end
            @(posedge clk);
            driveIdle();
            // last result drains
            repeat (3) @(posedge clk);
            finishChecks <= 1'b1;
            wait (checkDone === 1'b1);
            @(posedge clk);
        end
        totalErrors = mismatchCount + protocolCount + traceErrors;
        $display("error counts: mismatch %0d, protocol %0d, trace %0d, total %0d",
                 mismatchCount, protocolCount, traceErrors, totalErrors);
        if (totalErrors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // bound from trace length, worst-case gaps and reset
    initial begin
        wait (traceLoaded);
        #(watchdogCycles * CLK_PERIOD);
        $display("run timed out after %0d cycles without finishing", watchdogCycles);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire
